// ==== bench/tb_gyro_model.svh ====
`ifndef TB_GYRO_MODEL_SVH
`define TB_GYRO_MODEL_SVH

localparam int NUM_ROWS = 6;

// one test setup
// detector levels are raw ADC counts, periods counts checked errors
typedef struct packed {
	data_t                freq;
	data_t                amp_h;
	data_t                amp_l;
	logic                 polarity;
	data_t                wait_cnt;
	logic [AVG_SEL_W-1:0] avg_sel;
	data_t                offset;
	logic                 fb_on;
	logic [GAIN_W-1:0]    gain_sel;
	data_t                const_step;
	int                   adc_high;
	int                   adc_low;
	int                   periods;
} row_t;

row_t  tab[NUM_ROWS];
string tab_name[NUM_ROWS];

// freq kept at or above wait + 2^avg_sel + 8
// so the DAC check lands inside the low half
task automatic load_table();
	tab_name[0] = "ol_avg0";
	tab_name[1] = "ol_avg2_pol";
	tab_name[2] = "ol_avg4";
	tab_name[3] = "cl_neg_err";
	tab_name[4] = "cl_pol_rand";
	tab_name[5] = "ramp_wrap";
	// freq amp_h amp_l pol wait avg offset fb gain const high low periods
	tab[0] = '{24, 100, -100, 1'b0, 3, 4'd0, 5, 1'b0, 5'd0, 32'h0000_1234, 1500, -700, 3};
	tab[1] = '{28, 8192, -8192, 1'b1, 4, 4'd2, -40, 1'b0, 5'd0, -300, 0, 0, 3};
	tab[2] = '{40, 300, -250, 1'b0, 6, 4'd4, -1000, 1'b0, 5'd0, 77, 0, 0, 3};
	tab[3] = '{30, 500, -500, 1'b0, 5, 4'd2, 0, 1'b1, 5'd2, 0, -900, 600, 5};
	tab[4] = '{32, 1200, -1200, 1'b1, 3, 4'd4, 17, 1'b1, 5'd4, 0, 0, 0, 5};
	tab[5] = '{26, 64, -64, 1'b1, 3, 4'd0, 0, 1'b0, 5'd0, 32'h6ab3_91c5, 100, 90, 6};
	// random levels kept inside the 14 bit ADC range
	tab[1].adc_high = $random(seed) % 4096;
	tab[1].adc_low  = $random(seed) % 4096;
	tab[2].adc_high = $random(seed) % 4096;
	tab[2].adc_low  = $random(seed) % 4096;
	tab[4].adc_high = $random(seed) % 4096;
	tab[4].adc_low  = $random(seed) % 4096;
endtask

// averaged high minus low, sign flip, then offset
function automatic data_t err_expect(input row_t row);
	data_t sum_hi;
	data_t sum_lo;
	data_t avg_err;
	sum_hi  = row.adc_high * (1 << row.avg_sel);
	sum_lo  = row.adc_low * (1 << row.avg_sel);
	avg_err = (sum_hi - sum_lo) >>> row.avg_sel;
	if (row.polarity) begin
		avg_err = -avg_err;
	end
	return avg_err + row.offset;
endfunction

// integrator in closed loop, fixed step in open loop
function automatic data_t next_step(input data_t prev, input data_t err, input row_t row);
	if (row.fb_on) begin
		return prev + (err >>> row.gain_sel);
	end
	return row.const_step;
endfunction

// DAC word wraps at 16 bits
function automatic dac_t dac_word(input data_t ramp, input data_t amp);
	return dac_t'(ramp + amp);
endfunction

`endif

// ==== bench/tb_gyro_loop.sv ====
module tb_gyro_loop import gyro_pkg::*; ();

	localparam int ADC_BIT     = 14;
	localparam int RST_CYCLES  = 2;
	// ends well before the first error after reset
	localparam int IDLE_CYCLES = 20;

	logic                      CLOCK_DAC_1;
	logic                      i_arst_n;
	logic signed [ADC_BIT-1:0] i_adc;
	data_t                     i_freq_cnt;
	data_t                     i_amp_h;
	data_t                     i_amp_l;
	logic                      i_polarity;
	data_t                     i_wait_cnt;
	logic [AVG_SEL_W-1:0]      i_avg_sel;
	data_t                     i_err_offset;
	logic                      i_fb_on;
	logic [GAIN_W-1:0]         i_gain_sel;
	data_t                     i_const_step;
	mod_half_e                 o_mod_half;
	data_t                     o_err;
	logic                      o_err_valid;
	data_t                     o_step;
	dac_t                      o_dac;

	int seed = 32'h9a12_5943;

	// detector levels for the plant
	int lvl_high;
	int lvl_low;

	// step and ramp as the model sees them
	data_t model_step;
	data_t model_ramp;

	int   n_tests;
	int   n_checks;
	int   n_errors;
	int   row_checks;
	int   row_errs;
	logic timed_out;

	`include "tb_gyro_model.svh"

	gyro_loop_top #(
		.ADC_BIT (ADC_BIT)
	) i_gyro_loop_top (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_arst_n     (i_arst_n),
		.i_adc        (i_adc),
		.i_freq_cnt   (i_freq_cnt),
		.i_amp_h      (i_amp_h),
		.i_amp_l      (i_amp_l),
		.i_polarity   (i_polarity),
		.i_wait_cnt   (i_wait_cnt),
		.i_avg_sel    (i_avg_sel),
		.i_err_offset (i_err_offset),
		.i_fb_on      (i_fb_on),
		.i_gain_sel   (i_gain_sel),
		.i_const_step (i_const_step),
		.o_mod_half   (o_mod_half),
		.o_err        (o_err),
		.o_err_valid  (o_err_valid),
		.o_step       (o_step),
		.o_dac        (o_dac)
	);

	initial begin
		CLOCK_DAC_1 = 1'b0;
		forever #2 CLOCK_DAC_1 = ~CLOCK_DAC_1;
	end

	// detector plant follows the modulation half
	// levels latched on the edge, main process writes them 1 unit later
	initial begin : plant
		int hi;
		int lo;
		i_adc = '0;
		forever begin
			@(posedge CLOCK_DAC_1);
			hi = lvl_high;
			lo = lvl_low;
			#1;
			if (o_mod_half == HALF_HIGH) begin
				i_adc = hi[ADC_BIT-1:0];
			end else begin
				i_adc = lo[ADC_BIT-1:0];
			end
		end
	end

	// advance one cycle and land just after the edge
	task automatic tick();
		@(posedge CLOCK_DAC_1);
		#1;
	endtask

	task automatic check_value(input string test_name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		n_checks++;
		row_checks++;
		if (expected !== actual) begin
			$display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
			n_errors++;
			row_errs++;
		end
	endtask

	task automatic apply_row(input int r);
		i_freq_cnt   = tab[r].freq;
		i_amp_h      = tab[r].amp_h;
		i_amp_l      = tab[r].amp_l;
		i_polarity   = tab[r].polarity;
		i_wait_cnt   = tab[r].wait_cnt;
		i_avg_sel    = tab[r].avg_sel;
		i_err_offset = tab[r].offset;
		i_fb_on      = tab[r].fb_on;
		i_gain_sel   = tab[r].gain_sel;
		i_const_step = tab[r].const_step;
		lvl_high     = tab[r].adc_high;
		lvl_low      = tab[r].adc_low;
	endtask

	task automatic wait_valid(input int limit, output bit found);
		int n;
		found = 1'b0;
		n = 0;
		while (!found && n < limit) begin
			tick();
			n++;
			if (o_err_valid) begin
				found = 1'b1;
			end
		end
	endtask

	// one modulation period with the error, the step a cycle later
	// and the DAC 4 cycles later
	task automatic run_period(input int r, input bit discard);
		row_t  row;
		bit    found;
		data_t exp_err;
		data_t err_used;
		data_t amp;
		row = tab[r];
		wait_valid(8 * row.freq, found);
		if (!found) begin
			$display("timeout: o_err_valid did not arrive within %0d cycles in test %s",
				8 * row.freq, tab_name[r]);
			timed_out = 1'b1;
			n_errors++;
			row_errs++;
			return;
		end
		// the low sum completes inside the low half
		check_value(tab_name[r], "mod_half", 32'(HALF_LOW), 32'(o_mod_half));
		exp_err = err_expect(row);
		// integrator still runs on an unchecked error
		if (discard) begin
			err_used = o_err;
		end else begin
			check_value(tab_name[r], "err", exp_err, o_err);
			err_used = exp_err;
		end
		model_step = next_step(model_step, err_used, row);
		tick();
		check_value(tab_name[r], "step", model_step, o_step);
		// ramp picks up the fresh step on the trigger
		model_ramp = model_ramp + model_step;
		repeat (3) tick();
		amp = (o_mod_half == HALF_HIGH) ? row.amp_h : row.amp_l;
		check_value(tab_name[r], "dac", 32'(dac_word(model_ramp, amp)), 32'(o_dac));
	endtask

	task automatic report_row(input string name);
		if (row_errs == 0) begin
			$display("test %s ok, %0d checks", name, row_checks);
		end else begin
			$display("test %s failed, %0d of %0d checks wrong", name, row_errs, row_checks);
		end
	endtask

	initial begin
		i_arst_n     = 1'b0;
		i_freq_cnt   = 24;
		i_amp_h      = '0;
		i_amp_l      = '0;
		i_polarity   = 1'b0;
		i_wait_cnt   = 3;
		i_avg_sel    = '0;
		i_err_offset = '0;
		i_fb_on      = 1'b0;
		i_gain_sel   = '0;
		i_const_step = '0;
		lvl_high     = 0;
		lvl_low      = 0;
		model_step   = '0;
		model_ramp   = '0;
		n_tests      = 0;
		n_checks     = 0;
		n_errors     = 0;
		timed_out    = 1'b0;
		load_table();

		repeat (RST_CYCLES) @(posedge CLOCK_DAC_1);
		#1;
		i_arst_n = 1'b1;

		// quiet outputs until the first full period
		row_checks = 0;
		row_errs   = 0;
		for (int c = 0; c < IDLE_CYCLES; c++) begin
			tick();
			check_value("reset_idle", "mod_half", 32'(HALF_HIGH), 32'(o_mod_half));
			check_value("reset_idle", "err_valid", 32'd0, 32'(o_err_valid));
			check_value("reset_idle", "err", 32'd0, o_err);
			check_value("reset_idle", "step", 32'd0, o_step);
			check_value("reset_idle", "dac", 32'd0, 32'(o_dac));
		end
		report_row("reset_idle");
		n_tests++;

		for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
			row_checks = 0;
			row_errs   = 0;
			apply_row(r);
			// first error may straddle old and new setup
			run_period(r, 1'b1);
			for (int p = 0; p < tab[r].periods && !timed_out; p++) begin
				run_period(r, 1'b0);
			end
			report_row(tab_name[r]);
			n_tests++;
		end

		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+bench
verilog/gyro_pkg.sv
verilog/mod_gen.sv
verilog/err_signal_gen.sv
verilog/feedback_step_gen.sv
verilog/phase_ramp_gen.sv
verilog/gyro_loop_top.sv
bench/tb_gyro_loop.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the gyro loop testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_gyro_loop \
	-Mdir obj_dir -o tb_gyro_loop > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/tb_gyro_loop > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== verilog/err_signal_gen.sv ====
module err_signal_gen import gyro_pkg::*; #(
	parameter int ADC_BIT = 14
) (
	input  logic                      CLOCK_DAC_1,
	input  logic                      i_arst_n,
	input  logic signed [ADC_BIT-1:0] i_adc,
	input  mod_half_e                 i_mod_half,
	input  logic                      i_polarity,
	input  data_t                     i_wait_cnt,
	input  logic [AVG_SEL_W-1:0]      i_avg_sel,
	input  data_t                     i_err_offset,
	output data_t                     o_err,
	output logic                      o_err_valid,
	output logic                      o_ramp_trig
);

	// two-stage detector sample pipeline
	logic signed [ADC_BIT-1:0] adc_q1;
	logic signed [ADC_BIT-1:0] adc_q2;
	data_t smp;

	// half tracking
	mod_half_e half_q;
	mod_half_e acc_half;
	logic half_chg;

	// sequencing
	err_state_e state;
	data_t cnt;
	data_t n_smp;
	logic wait_end;
	logic last_smp;

	// accumulation and per-half sums
	data_t acc;
	data_t sum_h;
	data_t sum_l;
	logic high_vld;
	logic err_pend;

	// error arithmetic
	data_t diff;
	data_t scaled;
	data_t err_calc;

	// sample shifts through both stages every clock
	always_ff @(posedge CLOCK_DAC_1) begin
		adc_q1 <= i_adc;
		adc_q2 <= adc_q1;
	end

	// sign extend to the loop width
	assign smp = data_t'(adc_q2);

	// new half seen on its first cycle
	assign half_chg = (i_mod_half != half_q);

	// 2^avg_sel samples per half
	assign n_smp    = data_t'(32'd1 << i_avg_sel);
	assign wait_end = (cnt >= i_wait_cnt - 1);
	assign last_smp = (cnt >= n_smp - 1);

	// demodulated high minus low scaled back to one sample
	assign diff   = sum_h - sum_l;
	assign scaled = diff >>> i_avg_sel;

	// polarity flip, then bias trim
	assign err_calc = (i_polarity ? -scaled : scaled) + i_err_offset;

	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			half_q      <= HALF_HIGH;
			acc_half    <= HALF_HIGH;
			state       <= ERR_DONE;
			cnt         <= '0;
			acc         <= '0;
			sum_h       <= '0;
			sum_l       <= '0;
			high_vld    <= 1'b0;
			err_pend    <= 1'b0;
			o_err       <= '0;
			o_err_valid <= 1'b0;
			o_ramp_trig <= 1'b0;
		end else begin
			half_q   <= i_mod_half;
			err_pend <= 1'b0;

			if (half_chg) begin
				// restart the settle wait for the new half
				state    <= ERR_WAIT;
				acc_half <= i_mod_half;
				cnt      <= '0;
			end else begin
				case (state)
					ERR_WAIT: begin
						if (wait_end) begin
							state <= ERR_ACC;
							cnt   <= '0;
							acc   <= '0;
						end else begin
							cnt <= cnt + 1;
						end
					end
					ERR_ACC: begin
						acc <= acc + smp;
						cnt <= cnt + 1;
						if (last_smp) begin
							state <= ERR_DONE;
							if (acc_half == HALF_HIGH) begin
								sum_h    <= acc + smp;
								high_vld <= 1'b1;
							end else begin
								sum_l <= acc + smp;
								// only a full high/low pair yields an error
								err_pend <= high_vld;
							end
						end
					end
					default: begin
						// idle until the next half boundary
						state <= ERR_DONE;
					end
				endcase
			end

			// error out one cycle after the low sum lands
			o_err_valid <= err_pend;
			if (err_pend) begin
				o_err <= err_calc;
			end

			// ramp update trails the error by one cycle
			o_ramp_trig <= o_err_valid;
		end
	end

endmodule

// ==== verilog/feedback_step_gen.sv ====
module feedback_step_gen import gyro_pkg::*; (
	input  logic              CLOCK_DAC_1,
	input  logic              i_arst_n,
	input  data_t             i_err,
	input  logic              i_err_valid,
	input  logic              i_fb_on,
	input  logic [GAIN_W-1:0] i_gain_sel,
	input  data_t             i_const_step,
	output data_t             o_step
);

	// loop gain as an arithmetic shift of the error
	data_t err_scaled;

	// step value taken on the next error pulse
	data_t step_next;

	assign err_scaled = i_err >>> i_gain_sel;

	// closed loop integrates, open loop holds the fixed step
	always_comb begin
		if (i_fb_on) begin
			step_next = o_step + err_scaled;
		end else begin
			step_next = i_const_step;
		end
	end

	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_step <= '0;
		end else if (i_err_valid) begin
			// one update per modulation period
			o_step <= step_next;
		end
	end

endmodule

// ==== verilog/gyro_loop_top.sv ====
module gyro_loop_top import gyro_pkg::*; #(
	parameter int ADC_BIT = 14
) (
	input  logic                      CLOCK_DAC_1,
	input  logic                      i_arst_n,
	input  logic signed [ADC_BIT-1:0] i_adc,
	input  data_t                     i_freq_cnt,
	input  data_t                     i_amp_h,
	input  data_t                     i_amp_l,
	input  logic                      i_polarity,
	input  data_t                     i_wait_cnt,
	input  logic [AVG_SEL_W-1:0]      i_avg_sel,
	input  data_t                     i_err_offset,
	input  logic                      i_fb_on,
	input  logic [GAIN_W-1:0]         i_gain_sel,
	input  data_t                     i_const_step,
	output mod_half_e                 o_mod_half,
	output data_t                     o_err,
	output logic                      o_err_valid,
	output data_t                     o_step,
	output dac_t                      o_dac
);

	// bias modulation level toward the DAC sum
	data_t mod_out;

	// ramp update strobe
	logic ramp_trig;

	// square-wave bias for the phase modulator
	mod_gen u_mod_gen (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_arst_n    (i_arst_n),
		.i_freq_cnt  (i_freq_cnt),
		.i_amp_h     (i_amp_h),
		.i_amp_l     (i_amp_l),
		.o_mod_half  (o_mod_half),
		.o_mod_out   (mod_out)
	);

	// demodulated detector error, one per period
	err_signal_gen #(
		.ADC_BIT (ADC_BIT)
	) u_err_signal_gen (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_arst_n     (i_arst_n),
		.i_adc        (i_adc),
		.i_mod_half   (o_mod_half),
		.i_polarity   (i_polarity),
		.i_wait_cnt   (i_wait_cnt),
		.i_avg_sel    (i_avg_sel),
		.i_err_offset (i_err_offset),
		.o_err        (o_err),
		.o_err_valid  (o_err_valid),
		.o_ramp_trig  (ramp_trig)
	);

	// loop integrator
	feedback_step_gen u_feedback_step_gen (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_arst_n     (i_arst_n),
		.i_err        (o_err),
		.i_err_valid  (o_err_valid),
		.i_fb_on      (i_fb_on),
		.i_gain_sel   (i_gain_sel),
		.i_const_step (i_const_step),
		.o_step       (o_step)
	);

	// ramp plus modulation into the DAC
	phase_ramp_gen u_phase_ramp_gen (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_arst_n    (i_arst_n),
		.i_step      (o_step),
		.i_ramp_trig (ramp_trig),
		.i_mod_out   (mod_out),
		.o_dac       (o_dac)
	);

endmodule

// ==== verilog/gyro_pkg.sv ====
package gyro_pkg;

	// width of all loop arithmetic
	localparam int DATA_W = 32;

	// DAC word width
	// low bits of ramp plus modulation
	localparam int DAC_W = 16;

	// log2 of samples averaged per half
	// legal values 0 to 10
	localparam int AVG_SEL_W = 4;

	// right shift applied to the error in the integrator
	localparam int GAIN_W = 5;

	// signed loop word
	// amplitudes, error, offset, step and ramp all use it
	typedef logic signed [DATA_W-1:0] data_t;

	// unsigned raw word toward the DAC
	typedef logic [DAC_W-1:0] dac_t;

	// which half of the square-wave bias we are in
	typedef enum logic {
		HALF_LOW  = 1'b0,
		HALF_HIGH = 1'b1
	} mod_half_e;

	// error generator
	// wait for the detector to settle, sum the samples, then idle
	typedef enum logic [1:0] {
		ERR_WAIT = 2'd0,
		ERR_ACC  = 2'd1,
		ERR_DONE = 2'd2
	} err_state_e;

endpackage

// ==== verilog/mod_gen.sv ====
module mod_gen import gyro_pkg::*; (
	input  logic      CLOCK_DAC_1,
	input  logic      i_arst_n,
	input  data_t     i_freq_cnt,
	input  data_t     i_amp_h,
	input  data_t     i_amp_l,
	output mod_half_e o_mod_half,
	output data_t     o_mod_out
);

	// cycles spent so far in the current half
	data_t half_cnt;

	// one-cycle marker on the last cycle of a half
	logic half_end;

	// half that follows the current one
	mod_half_e next_half;

	// boundary once the count reaches the programmed half length
	// >= so a shorter length written on the fly still ends the half
	assign half_end = (half_cnt >= i_freq_cnt - 1);

	assign next_half = (o_mod_half == HALF_HIGH) ? HALF_LOW : HALF_HIGH;

	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			// start in the high half, output quiet until first clock
			half_cnt   <= '0;
			o_mod_half <= HALF_HIGH;
			o_mod_out  <= '0;
		end else begin
			if (half_end) begin
				// toggle half, amplitude follows in the same cycle
				half_cnt   <= '0;
				o_mod_half <= next_half;
				if (next_half == HALF_HIGH) begin
					o_mod_out <= i_amp_h;
				end else begin
					o_mod_out <= i_amp_l;
				end
			end else begin
				half_cnt <= half_cnt + 1;
				// keep tracking the amplitude level of this half
				if (o_mod_half == HALF_HIGH) begin
					o_mod_out <= i_amp_h;
				end else begin
					o_mod_out <= i_amp_l;
				end
			end
		end
	end

endmodule

// ==== verilog/phase_ramp_gen.sv ====
module phase_ramp_gen import gyro_pkg::*; (
	input  logic  CLOCK_DAC_1,
	input  logic  i_arst_n,
	input  data_t i_step,
	input  logic  i_ramp_trig,
	input  data_t i_mod_out,
	output dac_t  o_dac
);

	// serrodyne phase accumulator wrapping modulo 2^DATA_W
	data_t ramp;

	// low bits of ramp plus bias modulation
	dac_t dac_next;

	assign dac_next = ramp[DAC_W-1:0] + i_mod_out[DAC_W-1:0];

	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ramp <= '0;
		end else if (i_ramp_trig) begin
			// step was refreshed the cycle before the trigger
			ramp <= ramp + i_step;
		end
	end

	// registered DAC word
	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_dac <= '0;
		end else begin
			o_dac <= dac_next;
		end
	end

endmodule
